/* logic/nn_pkg.sv */
`default_nettype none

package nn_pkg;

  // network shape, eight hidden neurons fed by four input features
  localparam int N_HIDDEN    = 8;
  localparam int SAMPLE_BITS = 4;  // one feature per input bit
  localparam int WEIGHT_BITS = 4;  // weights run 1 to 8, so 4 bits are enough
  localparam int HIDDEN_BITS = 10; // largest hidden sum is 26 but the slot is 10 wide
  localparam int RESULT_BITS = 10; // largest output is 776, fits in 10 bits
  localparam int STEP_BITS   = 3;  // counts the eight output steps

  typedef logic [SAMPLE_BITS-1:0]            sample_t;     // the latched input sample
  typedef logic [WEIGHT_BITS-1:0]            weight_t;     // unsigned fixed weight
  typedef logic [HIDDEN_BITS-1:0]            hidden_t;     // one hidden neuron value
  typedef logic [N_HIDDEN*HIDDEN_BITS-1:0]   hidden_bus_t; // neuron 0 sits in the low bits
  typedef logic [RESULT_BITS-1:0]            result_t;     // the network output
  typedef logic [STEP_BITS-1:0]              step_t;       // output step index 0 to 7

  // controller states, the encoding is shown on the tile pins so it stays fixed
  typedef enum logic [2:0] {
    IDLE   = 3'd0, // waiting for a start edge
    HIDDEN = 3'd1, // one cycle where all hidden neurons load
    OUTPUT = 3'd2, // eight cycles of serial multiply-accumulate
    DONE   = 3'd3  // result valid and held
  } nn_state_e;

  // hidden layer weights, row i belongs to hidden neuron i
  // entry k of a row multiplies sample bit k
  localparam weight_t HIDDEN_W [N_HIDDEN][SAMPLE_BITS] = '{
    '{4'd1, 4'd2, 4'd3, 4'd4},
    '{4'd2, 4'd3, 4'd4, 4'd1},
    '{4'd3, 4'd4, 4'd1, 4'd2},
    '{4'd4, 4'd3, 4'd1, 4'd2},
    '{4'd5, 4'd6, 4'd7, 4'd8},
    '{4'd6, 4'd7, 4'd8, 4'd5},
    '{4'd7, 4'd8, 4'd5, 4'd6},
    '{4'd8, 4'd5, 4'd6, 4'd7}
  };

  // output layer weights, entry j multiplies hidden neuron j
  localparam weight_t OUTPUT_W [N_HIDDEN] = '{
    4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8
  };

endpackage

`default_nettype wire

/* logic/nn_control.sv */
`timescale 1ns/1ps
`default_nettype none

module nn_control (
  input  wire                clk_i,
  input  wire                rst_n_i,
  input  wire                start_i,     // level from the start pin, only its rising edge counts
  input  nn_pkg::sample_t    sample_i,    // live sample pins
  output nn_pkg::sample_t    sample_o,    // sample held for the whole run
  output logic               hidden_en_o, // hidden neurons load on this pulse
  output logic               clear_o,     // zeroes the output accumulator
  output logic               acc_en_o,    // high for the eight output steps
  output logic               last_o,      // marks the final output step
  output nn_pkg::step_t      step_o,      // which hidden value the output neuron takes
  output nn_pkg::nn_state_e  state_o,
  output logic               done_o,
  output logic               busy_o
);

  // the final step index, one less than the number of hidden neurons
  localparam nn_pkg::step_t LAST_STEP = nn_pkg::step_t'(nn_pkg::N_HIDDEN - 1);

  nn_pkg::nn_state_e state_q;
  nn_pkg::nn_state_e state_d;
  nn_pkg::sample_t   sample_q;
  nn_pkg::step_t     step_q;
  logic              start_q;      // start pin as seen one edge earlier
  logic              start_edge;   // start high now and low at the previous edge
  logic              start_accept; // an edge that actually begins a run
  logic              in_output;

  assign start_edge   = start_i & ~start_q;
  assign start_accept = start_edge &&
                        ((state_q == nn_pkg::IDLE) || (state_q == nn_pkg::DONE));
  assign in_output    = (state_q == nn_pkg::OUTPUT);

  // a start during HIDDEN or OUTPUT is simply not looked at
  always_comb begin
    state_d = state_q;
    case (state_q)
      nn_pkg::IDLE,
      nn_pkg::DONE: begin
        if (start_accept) begin
          state_d = nn_pkg::HIDDEN; // a new run may begin from either resting state
        end
      end
      nn_pkg::HIDDEN: begin
        state_d = nn_pkg::OUTPUT;   // the hidden layer needs a single cycle
      end
      nn_pkg::OUTPUT: begin
        if (step_q == LAST_STEP) begin
          state_d = nn_pkg::DONE;   // last product goes in on this edge
        end
      end
      default: begin
        state_d = nn_pkg::IDLE;     // unused encodings fall back to idle
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= nn_pkg::IDLE;
      start_q <= 1'b0; // a start held through reset gives an edge right after it
    end else begin
      state_q <= state_d;
      start_q <= start_i;
    end
  end

  // step counter runs only in OUTPUT and is parked at zero by the hidden cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_q <= '0;
    end else if (state_q == nn_pkg::HIDDEN) begin
      step_q <= '0;
    end else if (in_output) begin
      step_q <= step_q + 1'b1; // wraps to zero after the last step
    end
  end

  // the sample is captured on the accepting edge and held until the next run
  always_ff @(posedge clk_i) begin
    if (start_accept) begin
      sample_q <= sample_i;
    end
  end

  assign sample_o    = sample_q;
  assign hidden_en_o = (state_q == nn_pkg::HIDDEN);
  assign clear_o     = (state_q == nn_pkg::HIDDEN); // same pulse, accumulator restarts here
  assign acc_en_o    = in_output;
  assign last_o      = in_output && (step_q == LAST_STEP);
  assign step_o      = step_q;
  assign state_o     = state_q;

  // done and busy are plain decodes of the state
  assign done_o = (state_q == nn_pkg::DONE);
  assign busy_o = (state_q == nn_pkg::HIDDEN) || in_output;

endmodule

`default_nettype wire

/* logic/hidden_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module hidden_neuron #(
  parameter int NEURON_IDX = 0 // picks this neuron's row of the weight table
) (
  input  wire              clk_i,
  input  wire              rst_n_i,
  input  wire              en_i,     // load pulse from the controller
  input  nn_pkg::sample_t  sample_i, // latched sample, one feature per bit
  output nn_pkg::hidden_t  hidden_o
);

  nn_pkg::hidden_t sum;      // weighted sum of the set input bits
  nn_pkg::hidden_t hidden_q;

  // each set sample bit adds its weight, a cleared bit adds nothing
  // with binary inputs this is the whole dot product
  always_comb begin
    sum = '0;
    for (int k = 0; k < nn_pkg::SAMPLE_BITS; k++) begin
      if (sample_i[k]) begin
        sum = sum + nn_pkg::hidden_t'(nn_pkg::HIDDEN_W[NEURON_IDX][k]);
      end
    end
  end

  // the value is loaded once per run and held while the output layer reads it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hidden_q <= '0;
    end else if (en_i) begin
      hidden_q <= sum;
    end
  end

  assign hidden_o = hidden_q;

endmodule

`default_nettype wire

/* logic/output_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module output_neuron #(
  parameter nn_pkg::result_t CLASS_THRESHOLD = 10'd300 // class bit is set at or above this
) (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 clear_i,  // starts a fresh sum
  input  wire                 acc_en_i, // one product per cycle while high
  input  wire                 last_i,   // this cycle carries the final product
  input  nn_pkg::step_t       step_i,   // which hidden neuron is taken this cycle
  input  nn_pkg::hidden_bus_t hidden_i, // all eight hidden values side by side
  output nn_pkg::result_t     result_o,
  output logic                class_o
);

  nn_pkg::hidden_t hidden_sel; // hidden value picked by the step index
  nn_pkg::weight_t weight_sel; // its output weight
  nn_pkg::result_t product;
  nn_pkg::result_t sum_next;   // accumulator including this cycle's product
  nn_pkg::result_t acc_q;
  nn_pkg::result_t result_q;
  logic            class_q;

  // slice out the hidden value for this step, neuron 0 is in the low bits
  assign hidden_sel = hidden_i[step_i*nn_pkg::HIDDEN_BITS +: nn_pkg::HIDDEN_BITS];
  assign weight_sel = nn_pkg::OUTPUT_W[step_i];

  // largest product is 26 times 8, so the result width never overflows
  assign product  = nn_pkg::result_t'(hidden_sel) * nn_pkg::result_t'(weight_sel);
  assign sum_next = acc_q + product;

  // serial multiply-accumulate, one hidden neuron per cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;       // the hidden cycle comes right before the first step
    end else if (acc_en_i) begin
      acc_q <= sum_next;
    end
  end

  // the end of the sum is flagged by last_i, the step number is not decoded here
  // result and class then hold through DONE and the whole next run
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      class_q  <= 1'b0;
    end else if (last_i) begin
      result_q <= sum_next;                      // includes the final product
      class_q  <= (sum_next >= CLASS_THRESHOLD); // compare the same completed sum
    end
  end

  assign result_o = result_q;
  assign class_o  = class_q;

endmodule

`default_nettype wire

/* logic/tt_um_idann.sv */
`timescale 1ns/1ps
`default_nettype none

module tt_um_idann #(
  parameter nn_pkg::result_t CLASS_THRESHOLD = 10'd300 // passed on to the output neuron
) (
  input  wire       clk_i,
  input  wire       rst_n_i,
  input  wire       ena_i,     // high whenever the tile is powered, not needed here
  input  wire [7:0] ui_in_i,   // bits 3:0 are the sample, bit 7 is start
  input  wire [7:0] uio_in_i,  // bidirectional pins are all outputs
  output wire [7:0] uo_out_o,  // low byte of the result
  output wire [7:0] uio_out_o, // result high bits, flags and state
  output wire [7:0] uio_oe_o
);

  nn_pkg::sample_t     sample;     // sample as latched by the controller
  nn_pkg::hidden_bus_t hidden_bus; // every hidden neuron output, neuron 0 lowest
  nn_pkg::step_t       step;
  nn_pkg::nn_state_e   state;
  nn_pkg::result_t     result;
  logic                hidden_en;
  logic                clear;
  logic                acc_en;
  logic                last;
  logic                class_bit;
  logic                done;
  logic                busy;
  logic                unused;

  // enable, the bidirectional inputs and the spare input pins go nowhere
  assign unused = &{1'b0, ena_i, uio_in_i, ui_in_i[6:4]};

  nn_control i_control (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (ui_in_i[7]),
    .sample_i    (ui_in_i[3:0]),
    .sample_o    (sample),
    .hidden_en_o (hidden_en),
    .clear_o     (clear),
    .acc_en_o    (acc_en),
    .last_o      (last),
    .step_o      (step),
    .state_o     (state),
    .done_o      (done),
    .busy_o      (busy)
  );

  // eight hidden neurons share the sample and the load pulse, only the weights differ
  for (genvar i = 0; i < nn_pkg::N_HIDDEN; i++) begin : g_hidden
    hidden_neuron #(
      .NEURON_IDX (i)
    ) i_hidden (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .en_i     (hidden_en),
      .sample_i (sample),
      .hidden_o (hidden_bus[i*nn_pkg::HIDDEN_BITS +: nn_pkg::HIDDEN_BITS])
    );
  end

  output_neuron #(
    .CLASS_THRESHOLD (CLASS_THRESHOLD)
  ) i_output (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .clear_i  (clear),
    .acc_en_i (acc_en),
    .last_i   (last),
    .step_i   (step),
    .hidden_i (hidden_bus),
    .result_o (result),
    .class_o  (class_bit)
  );

  // the 10-bit result is split over the dedicated outputs and the low uio pins
  assign uo_out_o       = result[7:0];
  assign uio_out_o[1:0] = result[9:8];
  assign uio_out_o[2]   = class_bit;
  assign uio_out_o[3]   = done;
  assign uio_out_o[4]   = busy;
  assign uio_out_o[7:5] = state;    // controller state for debug on the pins
  assign uio_oe_o       = 8'hff;    // every uio pin drives

endmodule

`default_nettype wire

/* test/tb_nn_model.svh */
`ifndef TB_NN_MODEL_SVH
`define TB_NN_MODEL_SVH

`default_nettype none

// one hidden neuron, every set sample bit adds the weight in its column
function automatic int model_hidden(input int idx, input nn_pkg::sample_t sample);
  int sum;
  sum = 0;
  for (int k = 0; k < nn_pkg::SAMPLE_BITS; k++) begin
    if (sample[k]) begin
      sum += int'(nn_pkg::HIDDEN_W[idx][k]); // input bits are 0 or 1, no multiply needed
    end
  end
  return sum;
endfunction

// full network output, each hidden value times its output weight
function automatic int model_result(input nn_pkg::sample_t sample);
  int acc;
  acc = 0;
  for (int j = 0; j < nn_pkg::N_HIDDEN; j++) begin
    acc += model_hidden(j, sample) * int'(nn_pkg::OUTPUT_W[j]);
  end
  return acc; // largest value is 776, so it fits the 10-bit result without wrapping
endfunction

// class bit is set when the result reaches the threshold
function automatic int model_class(input int result, input int threshold);
  return (result >= threshold) ? 1 : 0;
endfunction

// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, the new bit enters at the bottom
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

`default_nettype wire

`endif

/* test/tb_nn.sv */
`timescale 1ns/1ps
`include "tb_nn_model.svh"
`default_nettype none

module tb_nn;

  localparam nn_pkg::result_t CLASS_THRESHOLD = 10'd300;
  localparam int N_RANDOM       = 200;
  localparam int TIMEOUT_CYCLES = 4000; // about 14 cycles per run, with margin for directed cases
  localparam int ST_IDLE   = 0;         // state encodings as they appear on uio_out[7:5]
  localparam int ST_HIDDEN = 1;
  localparam int ST_OUTPUT = 2;
  localparam int ST_DONE   = 3;

  logic        clk;
  logic        rst_n;
  logic        ena;
  logic [7:0]  ui_in;   // bit 7 is start, bits 3:0 the sample
  logic [7:0]  uio_in;
  wire  [7:0]  uo_out;
  wire  [7:0]  uio_out;
  wire  [7:0]  uio_oe;

  logic [15:0] lfsr_q = 16'd2848;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          error_cnt = 0;
  int          test_cnt = 0;
  int          test_fail_cnt = 0;
  int          test_checks_start;
  int          test_errors_start;
  string       test_name;
  int          held_result = 0; // what the result pins should show until the next run ends
  int          held_class = 0;

  tt_um_idann #(
    .CLASS_THRESHOLD (CLASS_THRESHOLD)
  ) i_dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .ena_i     (ena),
    .ui_in_i   (ui_in),
    .uio_in_i  (uio_in),
    .uo_out_o  (uo_out),
    .uio_out_o (uio_out),
    .uio_oe_o  (uio_oe)
  );

  always #4 clk = ~clk; // 8 ns period

  // hard stop in case the run never reaches its end
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // takes n fresh bits from the LFSR, one step per bit
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      error_cnt++;
      $display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  function automatic int dut_result();
    return int'({uio_out[1:0], uo_out}); // result is split over two pin groups
  endfunction

  task automatic check_flags(input int exp_state, input int exp_busy, input int exp_done);
    check_value("state", int'(uio_out[7:5]), exp_state);
    check_value("busy", int'(uio_out[4]), exp_busy);
    check_value("done", int'(uio_out[3]), exp_done);
  endtask

  task automatic check_outputs(input int exp_result, input int exp_class);
    check_value("result", dut_result(), exp_result);
    check_value("class", int'(uio_out[2]), exp_class);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_checks_start = check_cnt;
    test_errors_start = error_cnt;
  endtask

  task automatic end_test();
    int errs;
    errs = error_cnt - test_errors_start;
    test_cnt++;
    if (errs != 0) begin
      test_fail_cnt++;
    end
    $display("test %-16s %0d checks, %0d errors", test_name, check_cnt - test_checks_start, errs);
  endtask

  // one inference, checked on every falling edge from the start edge to DONE
  task automatic run_inference(input nn_pkg::sample_t s, input int exp_result, input int gap,
                               input bit poke_start, input bit hold_start);
    int exp_class;
    exp_class = model_class(exp_result, int'(CLASS_THRESHOLD));
    repeat (gap) @(negedge clk);
    @(negedge clk);
    ui_in = {1'b1, 3'b000, s};  // start rises, sampled at the next rising edge
    @(negedge clk);
    check_flags(ST_HIDDEN, 1, 0);
    check_outputs(held_result, held_class);
    ui_in[3:0] = ~s;            // pins change, the latched sample must not
    if (!hold_start) begin
      ui_in[7] = 1'b0;
    end
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_flags(ST_OUTPUT, 1, 0);
      check_outputs(held_result, held_class); // old result stays until the last step
      if (poke_start && i == 1) begin
        ui_in[7] = 1'b1;        // a rising edge while busy is ignored
      end
      if (poke_start && i == 4) begin
        ui_in[7] = 1'b0;
      end
    end
    @(negedge clk);
    check_flags(ST_DONE, 0, 1);
    check_outputs(exp_result, exp_class);
    held_result = exp_result;
    held_class  = exp_class;
    if (hold_start) begin
      repeat (4) begin
        @(negedge clk);
        check_flags(ST_DONE, 0, 1); // a level held high is not a new start
        check_outputs(held_result, held_class);
      end
      ui_in[7] = 1'b0;
    end
  endtask

  initial begin
    int v;
    int gap;
    nn_pkg::sample_t s;
    clk    = 1'b0;
    rst_n  = 1'b0;
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;

    begin_test("reset");
    repeat (16) begin
      @(negedge clk);
      check_flags(ST_IDLE, 0, 0);
      check_outputs(0, 0);
      check_value("uio_oe", int'(uio_oe), 255);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_flags(ST_IDLE, 0, 0);
    check_outputs(0, 0);
    check_value("uio_oe", int'(uio_oe), 255);
    end_test();

    begin_test("directed");
    run_inference(4'h0, 0, 1, 1'b0, 1'b0);   // all inputs off gives zero
    run_inference(4'hf, 776, 0, 1'b0, 1'b0); // all inputs on gives the largest output
    run_inference(4'h5, model_result(4'h5), 2, 1'b0, 1'b0);
    end_test();

    begin_test("ignored_starts");
    run_inference(4'h9, model_result(4'h9), 2, 1'b1, 1'b0);
    run_inference(4'h6, model_result(4'h6), 0, 1'b0, 1'b1);
    run_inference(4'h3, model_result(4'h3), 0, 1'b0, 1'b0); // fresh edge after the held level
    end_test();

    begin_test("random");
    for (int r = 0; r < N_RANDOM; r++) begin
      draw_bits(4, v);
      s = nn_pkg::sample_t'(v);
      draw_bits(2, gap);          // 0 to 3 idle cycles, 0 means back to back from DONE
      run_inference(s, model_result(s), gap, 1'b0, 1'b0);
    end
    end_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+test
logic/nn_pkg.sv
logic/nn_control.sv
logic/hidden_neuron.sv
logic/output_neuron.sv
logic/tt_um_idann.sv
test/tb_nn.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench and the DUT with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_nn \
  -Mdir obj_dir \
  -f build.f \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_nn)"
echo "$sim_out"

echo "$sim_out" | grep -qx "SIMULATION PASSED" \
  && { echo "run_sim: pass"; exit 0; } \
  || { echo "run_sim: fail"; exit 1; }
